/* cpc_support.f */
source/cpc_pkg.sv
source/rom_loader.sv
source/mf2_shadow.sv
source/tape_fetch.sv
source/multiface.sv
source/mem_gate.sv
source/cpc_support_top.sv
test/tb_cpc_support.sv

/* Makefile */
TOP = tb_cpc_support

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f cpc_support.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f cpc_support.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_cpc_support.sv */
// Testbench for the CPC support logic with tape memory model and checking assertions
`timescale 1ns/100ps

module tb_cpc_support import cpc_pkg::*; ();

	logic       clk_sys = 1'b0;
	logic       reset, cpc664, nmi_button, mem_ack_toggle, tape_data_req;
	cpu_bus_t   cpu;
	download_t  dl;
	mf2_mode_e  mf2_mode;
	logic [7:0] ram_dout, tape_din, tape_byte, cpu_din;
	mem_req_t   mem;
	tape_mem_t  tape_mem;
	logic       tape_data_ack, tape_restart, nmi;

	logic [255:0] loaded;        // Upper-ROM pages written so far
	logic [7:0]   tape_ram [256];
	logic [7:0]   tape_bytes [8];
	logic [22:0]  tape_addr_exp;
	logic [7:0]   tape_data_exp, din_exp;
	logic [8:0]   ext_base;
	logic [1:0]   map_expect;    // 1 mapped to MF2 page, 2 plain CPU address
	logic         rd_check = 1'b0, din_check = 1'b0, mf2_on = 1'b0;
	logic         old_wr = 1'b0, old_ack = 1'b0;
	int           wr_count = 0, play_idx = 0;

	cpc_support_top i_cpc_support_top (.*);

	always #5 clk_sys = ~clk_sys;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	// ROM block table of four cycling pages
	function automatic logic [8:0] rom_page(input int blk);
		case (blk % 4)
			0: return 9'h000;
			1: return 9'h100;
			2: return 9'h107;
			default: return 9'h1FF;
		endcase
	endfunction

	function automatic logic [3:0] hex_digit(input logic [7:0] c);
		return (c < "A") ? 4'(c - "0") : 4'(c - "A" + 10);
	endfunction

	task automatic boot_write(input logic [24:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		dl.addr <= addr;
		dl.data <= data;
		dl.wr   <= 1'b1;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cpu.cpu_addr <= addr;
		cpu.dout     <= data;
		cpu.io_wr    <= 1'b1;
		@(posedge clk_sys);
		cpu.io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	////////////////////
	// Tape memory that acks after 1 to 4 cycles
	initial begin : memory_model
		int delay;
		forever begin
			@(posedge clk_sys);
			if (!reset && (tape_mem.rd || tape_mem.wr)) begin
				delay = $urandom_range(4, 1);
				repeat (delay - 1) @(posedge clk_sys);
				if (tape_mem.wr)
					tape_ram[tape_mem.addr[7:0]] = tape_din;
				ram_dout       <= tape_ram[tape_mem.addr[7:0]];
				mem_ack_toggle <= ~mem_ack_toggle;
				repeat (2) @(posedge clk_sys);  // Request drops after the ack
			end
		end
	end

	always @(posedge clk_sys) begin
		old_wr  <= tape_mem.wr;
		old_ack <= tape_data_ack;
		if (!reset && tape_mem.wr && !old_wr) wr_count <= wr_count + 1;
		if (!reset && tape_data_ack != old_ack) play_idx <= play_idx + 1;
	end

	////////////////////
	// Checks
	a_rom_we: assert property (@(posedge clk_sys) disable iff (reset)
		dl.active && dl.index == 8'd0 && dl.wr |-> mem.we == (dl.addr[24:14] <= 11'd7))
		else fail_now($sformatf("mismatch mem.we: got %h expected %h",
			$sampled(mem.we), $sampled(dl.addr[24:14] <= 11'd7)));
	a_rom_page: assert property (@(posedge clk_sys) disable iff (reset)
		dl.active && dl.index == 8'd0 && dl.wr && dl.addr[24:14] <= 11'd7 |->
		mem.addr[22:14] == rom_page(dl.addr[16:14]) && mem.bank == {1'b0, dl.addr[16]})
		else fail_now($sformatf("mismatch mem.addr: got %h bank %h expected page %h bank %h",
			$sampled(mem.addr), $sampled(mem.bank), rom_page($sampled(dl.addr[16:14])),
			$sampled(dl.addr[16])));
	a_boot_din: assert property (@(posedge clk_sys) disable iff (reset)
		dl.active && (dl.index == 8'd0 || dl.index == 8'd3) && dl.wr |-> mem.din == dl.data)
		else fail_now($sformatf("mismatch mem.din: got %h expected %h",
			$sampled(mem.din), $sampled(dl.data)));
	a_ext_page: assert property (@(posedge clk_sys) disable iff (reset)
		dl.active && dl.index == 8'd3 && dl.wr |-> mem.we &&
		mem.addr[22:14] == ext_base + 9'(dl.addr[21:14]) && mem.bank == {1'b0, cpc664})
		else fail_now($sformatf("mismatch mem.addr: got %h we %h bank %h expected page %h",
			$sampled(mem.addr), $sampled(mem.we), $sampled(mem.bank),
			$sampled(ext_base + 9'(dl.addr[21:14]))));
	a_rom_read: assert property (@(posedge clk_sys) disable iff (reset)
		rd_check && cpu.mem_rd && cpu.mem_addr[22] |-> mem.oe == loaded[cpu.mem_addr[21:14]])
		else fail_now($sformatf("mismatch mem.oe: got %h expected %h",
			$sampled(mem.oe), $sampled(loaded[cpu.mem_addr[21:14]])));
	a_tape_addr: assert property (@(posedge clk_sys) disable iff (reset)
		tape_mem.wr |-> tape_mem.addr == tape_addr_exp)
		else fail_now($sformatf("mismatch tape_mem.addr: got %h expected %h",
			$sampled(tape_mem.addr), $sampled(tape_addr_exp)));
	a_tape_din: assert property (@(posedge clk_sys) disable iff (reset)
		tape_mem.wr |-> tape_din == tape_data_exp)
		else fail_now($sformatf("mismatch tape_din: got %h expected %h",
			$sampled(tape_din), $sampled(tape_data_exp)));
	// Restart is signalled while an image loads, not during playback
	a_tape_restart: assert property (@(posedge clk_sys) disable iff (reset)
		tape_mem.wr || tape_mem.rd |-> tape_restart == tape_mem.wr)
		else fail_now($sformatf("mismatch tape_restart: got %h expected %h",
			$sampled(tape_restart), $sampled(tape_mem.wr)));
	a_tape_byte: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(tape_data_ack) |-> tape_byte == tape_bytes[play_idx])
		else fail_now($sformatf("mismatch tape_byte: got %h expected %h",
			$sampled(tape_byte), tape_bytes[$sampled(play_idx)]));
	a_nmi_raise: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi_button) && !mf2_on && mf2_mode != MF2_DISABLED |=> nmi)
		else fail_now("nmi did not rise after the button press");
	a_nmi_entry: assert property (@(posedge clk_sys) disable iff (reset)
		nmi && $rose(cpu.m1) && cpu.cpu_addr == 16'h0066 |=> !nmi)
		else fail_now("nmi stayed high after the entry fetch");
	a_mf2_map: assert property (@(posedge clk_sys) disable iff (reset)
		map_expect == 2'd1 |-> mem.addr == {9'h1FF, 14'h0123})
		else fail_now($sformatf("mismatch mem.addr: got %h expected %h",
			$sampled(mem.addr), {9'h1FF, 14'h0123}));
	a_mf2_unmap: assert property (@(posedge clk_sys) disable iff (reset)
		map_expect == 2'd2 |-> mem.addr == cpu.mem_addr)
		else fail_now($sformatf("mismatch mem.addr: got %h expected %h",
			$sampled(mem.addr), $sampled(cpu.mem_addr)));
	a_cpu_din: assert property (@(posedge clk_sys) disable iff (reset)
		din_check |-> cpu_din == din_exp)
		else fail_now($sformatf("mismatch cpu_din: got %h expected %h",
			$sampled(cpu_din), $sampled(din_exp)));

	initial begin : stimulus
		int n;
		logic [7:0] colour;
		void'($urandom(76780));
		reset          <= 1'b1;
		cpu            <= '0;
		dl             <= '0;
		cpc664         <= 1'b1;
		mf2_mode       <= MF2_ENABLED;
		nmi_button     <= 1'b0;
		ram_dout       <= 8'hFF;
		mem_ack_toggle <= 1'b0;
		tape_data_req  <= 1'b0;
		loaded = '0;
		map_expect = 2'd0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		// ROM download where block 8 gives no write
		dl.index  <= 8'd0;
		dl.active <= 1'b1;
		for (int b = 0; b < 9; b++) begin
			boot_write({11'(b), 14'($urandom)}, 8'($urandom));
			if (b < 8 && rom_page(b)[8]) loaded[rom_page(b)[7:0]] = 1'b1;
		end
		dl.active <= 1'b0;

		// Expansion ROM 07
		@(posedge clk_sys);
		dl.index <= 8'd3;
		dl.ext   <= "07";
		ext_base = {1'b1, hex_digit("0"), hex_digit("7")};
		dl.active <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int b = 0; b < 2; b++) begin
			boot_write({11'(b), 14'($urandom)}, 8'($urandom));
			loaded[ext_base[7:0] + 8'(b)] = 1'b1;
		end
		dl.active <= 1'b0;
		@(posedge clk_sys);
		cpu.cpu_addr <= 16'hC123;
		cpu.mem_rd   <= 1'b1;
		cpu.mem_addr <= {1'b1, 8'h07, 14'h0123};
		rd_check = 1'b1;
		repeat (2) @(posedge clk_sys);
		cpu.mem_addr <= {1'b1, 8'h0A, 14'h0123};  // Never loaded
		repeat (2) @(posedge clk_sys);
		rd_check = 1'b0;
		cpu.mem_rd <= 1'b0;

		////////////////////
		// Tape image and playback
		dl.index  <= 8'd4;
		dl.active <= 1'b1;
		for (int i = 0; i < 6; i++) begin
			@(posedge clk_sys);
			tape_bytes[i] = 8'($urandom);
			tape_addr_exp = 23'(i);
			tape_data_exp = tape_bytes[i];
			dl.addr <= 25'(i);
			dl.data <= tape_bytes[i];
			dl.wr   <= 1'b1;
			n = 0;
			do begin
				@(posedge clk_sys);
				n++;
			end while (!tape_mem.wr && n < 50);
			if (!tape_mem.wr) fail_now("timeout waiting for a tape write request");
			dl.wr <= 1'b0;
			n = 0;
			do begin
				@(posedge clk_sys);
				n++;
			end while (tape_mem.wr && n < 50);
			if (tape_mem.wr) fail_now("timeout waiting for the tape write ack");
		end
		dl.active <= 1'b0;
		repeat (2) @(posedge clk_sys);
		assert (wr_count == 6)
			else fail_now($sformatf("mismatch wr_count: got %h expected %h", wr_count, 6));
		for (int i = 0; i < 6; i++) begin
			tape_data_req <= ~tape_data_req;
			n = 0;
			do begin
				@(posedge clk_sys);
				n++;
			end while (tape_data_ack != tape_data_req && n < 50);
			if (tape_data_ack != tape_data_req) fail_now("timeout waiting for tape_data_ack");
		end
		@(posedge clk_sys);
		assert (play_idx == 6)
			else fail_now($sformatf("mismatch play_idx: got %h expected %h", play_idx, 6));

		// NMI entry and Multiface paging
		nmi_button <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (!nmi && n < 20);
		if (!nmi) fail_now("timeout waiting for nmi");
		nmi_button   <= 1'b0;
		cpu.cpu_addr <= 16'h0066;
		cpu.m1       <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (nmi && n < 20);
		if (nmi) fail_now("timeout waiting for nmi to clear");
		mf2_on = 1'b1;
		cpu.m1       <= 1'b0;
		cpu.cpu_addr <= 16'h0123;
		cpu.mem_addr <= 23'h000123;
		@(posedge clk_sys);
		map_expect = 2'd1;
		repeat (2) @(posedge clk_sys);
		map_expect = 2'd0;
		io_write(16'hFEEA, 8'h00);
		cpu.cpu_addr <= 16'h0123;
		repeat (2) @(posedge clk_sys);
		mf2_on = 1'b0;
		map_expect = 2'd2;
		repeat (2) @(posedge clk_sys);
		map_expect = 2'd0;

		////////////////////
		// Shadowed colour of pen 3
		io_write(16'hFEE8, 8'h00);
		io_write(16'h7F00, 8'h03);
		colour = {2'b01, 6'($urandom)};
		io_write(16'h7F00, colour);
		cpu.cpu_addr <= 16'h3F93;
		cpu.mem_addr <= 23'h003F93;
		cpu.mem_rd   <= 1'b1;
		ram_dout     <= 8'hFF;  // Idle external bus
		repeat (3) @(posedge clk_sys);
		din_exp = colour;
		din_check = 1'b1;
		repeat (2) @(posedge clk_sys);
		din_check = 1'b0;
		cpu.cpu_addr <= 16'h8000;
		cpu.mem_addr <= 23'h008000;
		din_exp = 8'($urandom);
		ram_dout <= din_exp;
		din_check = 1'b1;
		repeat (2) @(posedge clk_sys);
		din_check = 1'b0;
		cpu.mem_rd <= 1'b0;
		@(posedge clk_sys);
		$display("all tests passed");
		$finish;
	end

endmodule

/* source/cpc_support_top.sv */
// Top level of the CPC support logic, loader, tape, Multiface and memory gate
`timescale 1ns/100ps

module cpc_support_top import cpc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	input  download_t  dl,
	input  logic       cpc664,
	input  mf2_mode_e  mf2_mode,
	input  logic       nmi_button,
	input  logic [7:0] ram_dout,
	input  logic       mem_ack_toggle,
	input  logic       tape_data_req,
	output mem_req_t   mem,
	output tape_mem_t  tape_mem,
	output logic [7:0] tape_din,
	output logic [7:0] tape_byte,
	output logic       tape_data_ack,
	output logic       tape_restart,
	output logic       nmi,
	output logic [7:0] cpu_din
);

	logic       boot_active, rom_absent, model;
	mem_req_t   boot_req;
	logic       mf2_rom_en, mf2_ram_en;
	logic [7:0] mf2_data;

	rom_loader i_rom_loader (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .model(model), .mf2_mode(mf2_mode),
		.mem_addr(cpu.mem_addr), .boot_active(boot_active), .boot_req(boot_req),
		.rom_absent(rom_absent)
	);

	tape_fetch i_tape_fetch (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .mem_ack_toggle(mem_ack_toggle),
		.ram_dout(ram_dout), .tape_data_req(tape_data_req), .tape_mem(tape_mem),
		.tape_din(tape_din), .tape_byte(tape_byte), .tape_data_ack(tape_data_ack),
		.tape_restart(tape_restart)
	);

	multiface i_multiface (
		.clk_sys(clk_sys), .reset(reset), .cpu(cpu), .mf2_mode(mf2_mode),
		.nmi_button(nmi_button), .nmi(nmi), .mf2_rom_en(mf2_rom_en),
		.mf2_ram_en(mf2_ram_en), .mf2_data(mf2_data)
	);

	mem_gate i_mem_gate (
		.clk_sys(clk_sys), .reset(reset), .cpu(cpu), .cpc664(cpc664),
		.boot_active(boot_active), .boot_req(boot_req), .rom_absent(rom_absent),
		.mf2_rom_en(mf2_rom_en), .mf2_ram_en(mf2_ram_en), .mf2_data(mf2_data),
		.ram_dout(ram_dout), .mem(mem), .model(model), .cpu_din(cpu_din)
	);

endmodule

/* source/mem_gate.sv */
// External memory request selection, model latch and CPU read bus merge
`timescale 1ns/100ps

module mem_gate import cpc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	input  logic       cpc664,
	input  logic       boot_active,
	input  mem_req_t   boot_req,
	input  logic       rom_absent,
	input  logic       mf2_rom_en,
	input  logic       mf2_ram_en,
	input  logic [7:0] mf2_data,
	input  logic [7:0] ram_dout,
	output mem_req_t   mem,
	output logic       model,
	output logic [7:0] cpu_din
);

	logic boot_sel;

	// Model only changes while in reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			model <= cpc664;
	end

	assign boot_sel = reset | boot_active;

	////////////////////
	// Request mux
	always_comb begin
		if (boot_sel)
			mem = boot_req;
		else begin
			mem.oe   = cpu.mem_rd & ~mf2_ram_en & ~rom_absent;
			mem.we   = cpu.mem_wr & ~mf2_ram_en & ~mf2_rom_en;
			mem.addr = mf2_rom_en ? {MF2_PAGE, cpu.cpu_addr[13:0]} : cpu.mem_addr;
			mem.bank = {1'b0, model};
			mem.din  = cpu.dout;
		end
	end

	assign cpu_din = ram_dout & mf2_data;  // Unselected sources give FF

endmodule

/* source/multiface.sv */
// Multiface Two NMI, enable and hide control, and ROM and RAM paging decode
`timescale 1ns/100ps

module multiface import cpc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	input  mf2_mode_e  mf2_mode,
	input  logic       nmi_button,
	output logic       nmi,
	output logic       mf2_rom_en,
	output logic       mf2_ram_en,
	output logic [7:0] mf2_data
);

	logic mf2_en, hidden;
	logic old_btn, old_m1, old_io_wr;
	logic btn_rise, m1_rise, io_rise, port_hit;

	assign btn_rise = nmi_button & ~old_btn;
	assign m1_rise  = cpu.m1 & ~old_m1;
	assign io_rise  = cpu.io_wr & ~old_io_wr;
	assign port_hit = (cpu.cpu_addr[15:2] == MF2_PORT);  // FEE8 or FEEA

	always_ff @(posedge clk_sys) begin
		old_btn   <= nmi_button;
		old_m1    <= cpu.m1;
		old_io_wr <= cpu.io_wr;
		if (reset) begin
			mf2_en <= 1'b0;
			hidden <= (mf2_mode != MF2_ENABLED);
			nmi    <= 1'b0;
		end else begin
			if (btn_rise & ~mf2_en & (mf2_mode != MF2_DISABLED))
				nmi <= 1'b1;
			// CPU takes the NMI
			if (nmi & m1_rise & (cpu.cpu_addr == NMI_ENTRY)) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (mf2_en & m1_rise & (cpu.cpu_addr == NMI_HIDE))
				hidden <= 1'b1;
			if (io_rise & port_hit)
				mf2_en <= ~cpu.cpu_addr[1] & ~hidden;  // FEEA pages out
		end
	end

	////////////////////
	// Paging with ROM at 0000 and RAM at 2000
	assign mf2_rom_en = mf2_en & (cpu.cpu_addr[15:13] == 3'b000);
	assign mf2_ram_en = mf2_en & (cpu.cpu_addr[15:13] == 3'b001);

	mf2_shadow i_mf2_shadow (
		.clk_sys (clk_sys),
		.cpu     (cpu),
		.ram_en  (mf2_ram_en),
		.rd_data (mf2_data)
	);

endmodule

/* source/tape_fetch.sv */
// Tape image write requests and byte fetch for the tape player
`timescale 1ns/100ps

module tape_fetch import cpc_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  download_t   dl,
	input  logic        mem_ack_toggle,
	input  logic [7:0]  ram_dout,
	input  logic        tape_data_req,
	output tape_mem_t   tape_mem,
	output logic [7:0]  tape_din,
	output logic [7:0]  tape_byte,
	output logic        tape_data_ack,
	output logic        tape_restart
);

	logic        old_strobe, old_ack;
	logic        wr_req, rd_req;
	logic        wr_pend;  // Strobe seen while memory busy
	logic [22:0] wr_addr, play_addr, last_addr;
	logic        tape_dl, strobe_rise, ack_seen, busy, play_req;

	assign tape_dl     = (dl_kind(dl) == DL_TAPE);
	assign strobe_rise = tape_dl & dl.wr & ~old_strobe;
	assign ack_seen    = mem_ack_toggle ^ old_ack;
	assign busy        = wr_req | rd_req;
	assign play_req    = tape_data_req ^ tape_data_ack;

	assign tape_mem.wr   = wr_req;
	assign tape_mem.rd   = rd_req;
	assign tape_mem.addr = wr_req ? wr_addr : play_addr;

	always_ff @(posedge clk_sys) begin
		old_strobe <= dl.wr;
		old_ack    <= mem_ack_toggle;
		if (reset) begin
			wr_req        <= 1'b0;
			rd_req        <= 1'b0;
			wr_pend       <= 1'b0;
			play_addr     <= 23'd0;
			last_addr     <= 23'd0;
			tape_restart  <= 1'b1;
			tape_data_ack <= tape_data_req;
		end else begin
			tape_restart <= tape_dl;
			if (ack_seen & busy) begin  // Request done
				wr_req <= 1'b0;
				rd_req <= 1'b0;
				if (rd_req) begin
					tape_byte     <= ram_dout;
					tape_data_ack <= tape_data_req;
					play_addr     <= play_addr + 23'd1;
				end
			end else if ((strobe_rise | wr_pend) & ~busy) begin
				wr_req   <= 1'b1;
				wr_pend  <= 1'b0;
				wr_addr  <= dl.addr[22:0];
				tape_din <= dl.data;
			end else if (~dl.active & ~busy & play_req & (play_addr <= last_addr))
				rd_req <= 1'b1;

			if (strobe_rise) begin
				last_addr <= dl.addr[22:0];
				if (busy) wr_pend <= 1'b1;
			end
			if (tape_dl & ~rd_req) play_addr <= 23'd0;  // Rewind on new image
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(tape_mem.rd && tape_mem.wr));
	// Request and address hold until the memory answers
	a_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(tape_mem.wr || tape_mem.rd) && !ack_seen |=> $stable(tape_mem));

endmodule

/* source/mf2_shadow.sv */
// Shadow copies of hardware register writes and the 8 KB Multiface RAM
`timescale 1ns/100ps

module mf2_shadow import cpc_pkg::*; (
	input  logic       clk_sys,
	input  cpu_bus_t   cpu,
	input  logic       ram_en,
	output logic [7:0] rd_data
);

	logic [7:0]  ram [8192];
	logic [12:0] ram_a;
	logic [7:0]  ram_in, ram_out;
	logic        ram_we;
	logic [4:0]  pen_index;
	logic [3:0]  crtc_reg;
	logic [12:0] store_addr;
	logic        old_io_wr;
	ga_cmd_e     ga_cmd;

	assign ga_cmd = ga_cmd_e'(cpu.dout[7:6]);

	////////////////////
	// Where each port write is kept
	always_comb begin
		case (cpu.cpu_addr[15:8])
			8'h7F:
				case (ga_cmd)
					GA_PEN:   store_addr = 13'h1FCF;
					GA_COLOR: store_addr = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
					GA_MODE:  store_addr = 13'h1FEF;
					default:  store_addr = 13'h1FFF;  // Banking
				endcase
			8'hBC:   store_addr = 13'h1CFF;  // CRTC select
			8'hBD:   store_addr = {9'h1DB, crtc_reg};
			8'hF7:   store_addr = 13'h17FF;  // PPI control
			8'hDF:   store_addr = 13'h1AAC;  // Upper ROM select
			default: store_addr = 13'd0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		old_io_wr <= cpu.io_wr;
		if (cpu.io_wr & ~old_io_wr & (|store_addr)) begin
			if (cpu.cpu_addr[15:8] == 8'h7F && ga_cmd == GA_PEN)
				pen_index <= cpu.dout[4:0];
			if (cpu.cpu_addr[15:8] == 8'hBC)
				crtc_reg <= cpu.dout[3:0];
			ram_a  <= store_addr;
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else if (cpu.mem_wr & ram_en) begin
			ram_a  <= cpu.mem_addr[12:0];
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= cpu.mem_addr[12:0];
			ram_we <= 1'b0;
		end
	end

	// Write-through RAM port
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else
			ram_out <= ram[ram_a];
	end

	assign rd_data = (ram_en & cpu.mem_rd) ? ram_out : 8'hFF;

endmodule

/* source/rom_loader.sv */
// Download decoding, boot write mapping, expansion page and upper-ROM presence map
`timescale 1ns/100ps

module rom_loader import cpc_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  download_t   dl,
	input  logic        model,
	input  mf2_mode_e   mf2_mode,
	input  logic [22:0] mem_addr,
	output logic        boot_active,
	output mem_req_t    boot_req,
	output logic        rom_absent
);

	dl_kind_e    kind;
	logic        rom_dl, ext_dl;
	logic [10:0] block;     // 16 KB block of the download
	logic        blk_ok;
	logic [8:0]  page;      // Expansion base page
	logic        combo;     // Z0 file waiting for end of first block
	logic        remap;     // Rest of a Z0 file goes to the MF2 page
	logic        old_wr, old_active;
	logic [4:0]  hi_nib, lo_nib;
	logic [255:0] rom_map = '0;  // Upper-ROM pages present

	// Valid flag and value of one hex character
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b1, c[3:0] + 4'd9};
		return 5'd0;
	endfunction

	assign kind        = dl_kind(dl);
	assign rom_dl      = (kind == DL_ROM);
	assign ext_dl      = (kind == DL_EXT);
	assign boot_active = rom_dl | ext_dl;
	assign block       = dl.addr[24:14];
	assign hi_nib      = hex_nibble(dl.ext[15:8]);
	assign lo_nib      = hex_nibble(dl.ext[7:0]);

	////////////////////
	// Boot write mapping
	always_comb begin
		boot_req.oe   = 1'b0;
		boot_req.din  = dl.data;
		boot_req.addr = {MF2_PAGE, dl.addr[13:0]};
		boot_req.bank = 2'd0;
		blk_ok        = 1'b1;
		if (ext_dl) begin
			if (!remap) begin
				boot_req.addr[22]    = page[8];
				boot_req.addr[21:14] = page[7:0] + dl.addr[21:14];
			end
			boot_req.bank = {1'b0, model};
		end else begin
			case (block)
				11'd0, 11'd4: boot_req.addr[22:14] = 9'h000;  // OS
				11'd1, 11'd5: boot_req.addr[22:14] = 9'h100;  // BASIC
				11'd2, 11'd6: boot_req.addr[22:14] = 9'h107;  // AMSDOS
				11'd3, 11'd7: boot_req.addr[22:14] = MF2_PAGE;
				default:      blk_ok = 1'b0;
			endcase
			boot_req.bank = {1'b0, block[2]};  // Blocks 4 to 7 in bank 1
		end
		boot_req.we = boot_active & dl.wr & blk_ok;
	end

	always_ff @(posedge clk_sys) begin
		old_wr     <= dl.wr;
		old_active <= dl.active;
		if (reset) begin
			page  <= 9'd0;
			combo <= 1'b0;
			remap <= 1'b0;
		end else begin
			// End of a boot write
			if (boot_active & blk_ok & old_wr & ~dl.wr) begin
				if (boot_req.addr[22])
					rom_map[boot_req.addr[21:14]] <= 1'b1;
				if (combo & (&dl.addr[13:0])) begin
					combo <= 1'b0;
					remap <= 1'b1;
				end
			end
			// Page from the extension at download start
			if (~old_active & dl.active & ext_dl) begin
				page  <= MALFORMED_PAGE;
				combo <= 1'b0;
				remap <= 1'b0;
				if (hi_nib[4]) page[7:4] <= hi_nib[3:0];
				if (lo_nib[4]) page[3:0] <= lo_nib[3:0];
				if (dl.ext == "ZZ") page <= 9'd0;
				if (dl.ext == "Z0") begin
					page  <= 9'd0;
					combo <= 1'b1;
				end
			end
		end
	end

	// Missing upper ROMs, and the MF2 page when the device is off
	assign rom_absent = mem_addr[22] & (~rom_map[mem_addr[21:14]] |
		((&mem_addr[21:14]) & (mf2_mode == MF2_DISABLED)));

	a_boot_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		boot_req.we |-> dl.active && (dl.index == 8'd0 || dl.index == 8'd3));

endmodule

/* source/cpc_pkg.sv */
// Bus structs, download and Multiface enums, memory-map constants
package cpc_pkg;

	// One bus cycle from the CPU board
	typedef struct packed {
		logic [15:0] cpu_addr;
		logic [22:0] mem_addr;  // Physical RAM address
		logic [7:0]  dout;
		logic        mem_rd;
		logic        mem_wr;
		logic        io_rd;
		logic        io_wr;
		logic        m1;
	} cpu_bus_t;

	// File download port
	typedef struct packed {
		logic        active;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
		logic [15:0] ext;  // Two ASCII characters
	} download_t;

	typedef struct packed {
		logic        oe;
		logic        we;
		logic [22:0] addr;
		logic [1:0]  bank;
		logic [7:0]  din;
	} mem_req_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [22:0] addr;
	} tape_mem_t;

	typedef enum logic [1:0] {DL_NONE, DL_ROM, DL_EXT, DL_TAPE} dl_kind_e;
	typedef enum logic [1:0] {MF2_ENABLED, MF2_HIDDEN, MF2_DISABLED} mf2_mode_e;
	typedef enum logic [1:0] {GA_PEN, GA_COLOR, GA_MODE, GA_BANK} ga_cmd_e;  // Data bits 7:6

	////////////////////
	// Memory map
	localparam logic [8:0]  MF2_PAGE       = 9'h1FF;
	localparam logic [8:0]  MALFORMED_PAGE = 9'h1EE;  // Unused page
	localparam logic [15:0] NMI_ENTRY      = 16'h0066;
	localparam logic [15:0] NMI_HIDE       = 16'h0065;
	localparam logic [13:0] MF2_PORT       = 14'b11111110111010;  // FEE8 and FEEA

	// Download kind from the index
	function automatic dl_kind_e dl_kind(input download_t d);
		dl_kind_e k;
		case (d.index)
			8'd0: k = DL_ROM;
			8'd3: k = DL_EXT;
			8'd4: k = DL_TAPE;
			default: k = DL_NONE;
		endcase
		return d.active ? k : DL_NONE;
	endfunction

endpackage
